//--- kbd_subsys.f
+incdir+hdl
hdl/pet_kbd_pkg.sv
hdl/cpu_bus_timing.sv
hdl/io_decode.sv
hdl/keyboard.sv
hdl/kbd_subsys.sv
tb/kbd_subsys_sva.sv
tb/tb_kbd_subsys.sv

//--- Makefile
# Verilator build and run of the PET keyboard subsystem testbench

TOP := tb_kbd_subsys

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

obj_dir/V$(TOP): kbd_subsys.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f kbd_subsys.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "^No errors$$" sim.log || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_kbd_subsys.sv
// Testbench for the PET keyboard subsystem
// Plays MCU bridge and 6502, checks against a matrix reference model
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module tb_kbd_subsys;
    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 10;                 // After the rising edge
    localparam int RESET_CYCLES  = 8;
    localparam int ACK_WAIT      = 4;                  // Clocks allowed for an acknowledge
    localparam int RAND_OPS      = 200;
    // Worst case clocks per access, directed access counts rounded up
    localparam int WB_OP_CLOCKS  = 2 + ACK_WAIT;
    localparam int CPU_OP_CLOCKS = 2 * `CPU_CYCLE_CLOCKS + 1;
    localparam int DIR_WB_OPS    = 40;
    localparam int DIR_CPU_OPS   = 24;
    localparam int TEST_CLOCKS   = RESET_CYCLES + DIR_WB_OPS * WB_OP_CLOCKS
                                   + (DIR_CPU_OPS + RAND_OPS) * CPU_OP_CLOCKS;
    localparam int TIMEOUT_CLOCKS = 2 * TEST_CLOCKS;

    localparam logic [`WB_ADDR_WIDTH-1:0]  KBD_BASE  = `KBD_WB_BASE;
    localparam logic [`CPU_ADDR_WIDTH-1:0] PIA1_ADDR = `PIA1_BASE;

    logic                   wb_clock;
    logic                   rst;
    pet_kbd_pkg::wb_req_t   wb_req;
    pet_kbd_pkg::cpu_bus_t  cpu_bus;
    pet_kbd_pkg::wb_rsp_t   wb_rsp;
    logic [`DATA_WIDTH-1:0] cpu_data;
    logic                   cpu_data_oe;
    logic                   cpu_be;
    logic                   cpu_data_strobe;

    // Reference model, rows active low
    logic [`KBD_ROW_COUNT-1:0] ref_usb [`KBD_COL_COUNT];
    logic [`KBD_ROW_COUNT-1:0] ref_pet [`KBD_COL_COUNT];
    logic [`KBD_COL_WIDTH-1:0] ref_col;

    logic [31:0] rng;
    int wb_errors;
    int cpu_errors;
    int timing_errors;
    int other_errors;
    int cycle_count;

    kbd_subsys u_dut (
        .wb_clock_i        (wb_clock),
        .rst_i             (rst),
        .wb_req_i          (wb_req),
        .cpu_bus_i         (cpu_bus),
        .wb_rsp_o          (wb_rsp),
        .cpu_data_o        (cpu_data),
        .cpu_data_oe_o     (cpu_data_oe),
        .cpu_be_o          (cpu_be),
        .cpu_data_strobe_o (cpu_data_strobe)
    );

    always #CLK_HALF wb_clock = ~wb_clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Port A byte built through the PET field view
    function automatic logic [7:0] porta_byte(input logic [3:0] col, input logic [3:0] sense);
        pet_kbd_pkg::pia1_porta_u pa;
        pa.raw          = '0;
        pa.f.diag       = sense[3];
        pa.f.eoi        = sense[2];
        pa.f.cass_sense = sense[1:0];
        pa.f.key_col    = col;
        return pa.raw;
    endfunction

    function automatic logic is_pia1(input logic [15:0] addr);
        return addr[15:4] == PIA1_ADDR[15:4];           // 16 byte window
    endfunction

    function automatic logic is_portb_read(input logic [15:0] addr, input logic we);
        return is_pia1(addr) && !we && (pet_kbd_pkg::pia_rs_e'(addr[1:0]) == pet_kbd_pkg::PORTB);
    endfunction

    // Expected override byte, FF when no USB key is down
    function automatic logic [7:0] ref_override();
        if (ref_col < `KBD_COL_COUNT) begin
            return ref_usb[ref_col];
        end
        return 8'hFF;
    endfunction

    function automatic logic [7:0] ref_wb_read(input logic [3:0] col);
        if (col < `KBD_COL_COUNT) begin
            return ref_pet[col];
        end
        return 8'hFF;                                   // Holes 10..15
    endfunction

    function automatic void model_wb_write(input logic [3:0] col, input logic [7:0] dat);
        if (col < `KBD_COL_COUNT) begin
            ref_usb[col] = dat;
        end
    endfunction

    function automatic void model_cpu(input logic [15:0] addr, input logic [7:0] data,
                                      input logic we);
        pet_kbd_pkg::pia1_porta_u pa;
        pa.raw = data;
        if (is_pia1(addr) && we && (pet_kbd_pkg::pia_rs_e'(addr[1:0]) == pet_kbd_pkg::PORTA)) begin
            ref_col = pa.f.key_col;
        end
        if (is_portb_read(addr, we) && (ref_col < `KBD_COL_COUNT)) begin
            ref_pet[ref_col] = data;                    // Real PIA rows captured
        end
    endfunction

    task automatic check_wb_rsp(input string name, input pet_kbd_pkg::wb_rsp_t exp,
                                input pet_kbd_pkg::wb_rsp_t act);
        if (act !== exp) begin
            wb_errors++;
            $display("Error %s: expected dat %h ack %b, actual dat %h ack %b",
                     name, exp.dat, exp.ack, act.dat, act.ack);
        end
    endtask

    task automatic check_cpu_override(input string name, input logic exp_oe,
                                      input logic [7:0] exp_data, input logic act_oe,
                                      input logic [7:0] act_data);
        if (act_oe !== exp_oe) begin
            cpu_errors++;
            $display("Error %s: expected oe %b, actual oe %b", name, exp_oe, act_oe);
        end else if (exp_oe && (act_data !== exp_data)) begin
            cpu_errors++;
            $display("Error %s: expected data %h, actual data %h", name, exp_data, act_data);
        end
    endtask

    task automatic check_bus_phase(input string name, input logic exp_be, input logic exp_strobe,
                                   input logic act_be, input logic act_strobe);
        if ((act_be !== exp_be) || (act_strobe !== exp_strobe)) begin
            timing_errors++;
            $display("Error %s: expected be %b strobe %b, actual be %b strobe %b",
                     name, exp_be, exp_strobe, act_be, act_strobe);
        end
    endtask

    // One pipelined request, then wait for the acknowledge
    task automatic wb_access(input logic [16:0] adr, input logic [7:0] dat, input logic we,
                             input logic expect_ack, output pet_kbd_pkg::wb_rsp_t rsp);
        int  waited;
        logic got;
        @(posedge wb_clock);
        #DRIVE_DELAY;
        wb_req = '{adr: adr, dat: dat, we: we, cyc: 1'b1, stb: 1'b1};
        @(posedge wb_clock);
        #DRIVE_DELAY;
        wb_req = '0;
        rsp    = '0;
        got    = 1'b0;
        waited = 0;
        while (!got && (waited < ACK_WAIT)) begin
            @(negedge wb_clock);
            if (wb_rsp.ack === 1'b1) begin
                got = 1'b1;
                rsp = wb_rsp;
            end
            waited++;
        end
        if (expect_ack && !got) begin
            other_errors++;
            $display("Wishbone access to %h was never acknowledged", adr);
        end else if (!expect_ack && got) begin
            other_errors++;
            $display("Wishbone access to %h outside the window was acknowledged", adr);
        end
    endtask

    // Start at the next CPU cycle, hold the bus for all 16 clocks
    task automatic cpu_access(input logic [15:0] addr, input logic [7:0] data, input logic we,
                              output logic oe, output logic [7:0] dout);
        int phase;
        @(negedge wb_clock);
        while (cpu_data_strobe !== 1'b1) begin
            @(negedge wb_clock);
        end
        @(posedge wb_clock);
        #DRIVE_DELAY;
        cpu_bus = '{addr: addr, data: data, we: we};
        for (phase = 0; phase < `CPU_CYCLE_CLOCKS; phase++) begin
            @(negedge wb_clock);                        // Middle of each phase
            check_bus_phase("cpu bus phase", phase >= `CPU_BE_START,
                            phase == `CPU_CYCLE_CLOCKS - 1, cpu_be, cpu_data_strobe);
        end
        oe   = cpu_data_oe;                             // Phase 15, override settled
        dout = cpu_data;
        @(posedge wb_clock);                            // Strobe edge
        #DRIVE_DELAY;
        cpu_bus = '0;
    endtask

    task automatic do_wb(input string name, input logic [16:0] adr, input logic [7:0] dat,
                         input logic we);
        pet_kbd_pkg::wb_rsp_t exp;
        pet_kbd_pkg::wb_rsp_t act;
        logic in_win;
        in_win  = (adr[16:4] == KBD_BASE[16:4]);
        exp.ack = 1'b1;
        exp.dat = ref_wb_read(adr[3:0]);                // PET column before the access
        wb_access(adr, dat, we, in_win, act);
        if (in_win) begin
            check_wb_rsp(name, exp, act);
        end
        if (in_win && we) begin
            model_wb_write(adr[3:0], dat);
        end
    endtask

    task automatic do_cpu(input string name, input logic [15:0] addr, input logic [7:0] data,
                          input logic we);
        logic [7:0] exp_data;
        logic [7:0] act_data;
        logic       exp_oe;
        logic       act_oe;
        exp_data = ref_override();
        exp_oe   = is_portb_read(addr, we) && (exp_data != 8'hFF);
        cpu_access(addr, data, we, act_oe, act_data);
        check_cpu_override(name, exp_oe, exp_data, act_oe, act_data);
        model_cpu(addr, data, we);
    endtask

    always @(posedge wb_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CLOCKS) begin
            $display("Timeout, the run did not finish within %0d clocks", TIMEOUT_CLOCKS);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int         i;
        int         kind;
        logic [3:0] col;
        logic [7:0] dat;
        wb_clock      = 1'b0;
        rst           = 1'b1;
        wb_req        = '0;
        cpu_bus       = '0;
        wb_errors     = 0;
        cpu_errors    = 0;
        timing_errors = 0;
        other_errors  = 0;
        cycle_count   = 0;
        rng           = 32'd71540;
        for (i = 0; i < `KBD_COL_COUNT; i++) begin
            ref_usb[i] = 8'hFF;
            ref_pet[i] = 8'hFF;
        end
        ref_col = '0;
        repeat (RESET_CYCLES) @(posedge wb_clock);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Reset state
        @(negedge wb_clock);
        if ((wb_rsp.ack !== 1'b0) || (cpu_data_oe !== 1'b0)) begin
            other_errors++;
            $display("Acknowledge or override enable is not low after reset");
        end
        for (i = 0; i < `KBD_COL_COUNT; i++) begin
            do_wb("reset read", KBD_BASE | 17'(i), 8'h00, 1'b0);
        end

        // USB key down overrides port B
        do_wb("usb write col 3", KBD_BASE | 17'd3, 8'hEF, 1'b1);
        do_cpu("select col 3", PIA1_ADDR, porta_byte(4'd3, 4'b1010), 1'b1);
        do_cpu("key down col 3", PIA1_ADDR + 16'd2, 8'hFF, 1'b0);
        do_cpu("select col 5", PIA1_ADDR, porta_byte(4'd5, 4'b0101), 1'b1);
        do_cpu("no key col 5", PIA1_ADDR + 16'd2, 8'hFF, 1'b0);
        do_wb("usb write col 5", KBD_BASE | 17'd5, 8'h7F, 1'b1);
        do_cpu("key down col 5", PIA1_ADDR + 16'd2, 8'hFF, 1'b0);

        // PET matrix capture and readback
        do_cpu("select col 7", PIA1_ADDR, porta_byte(4'd7, 4'b0000), 1'b1);
        do_cpu("capture col 7", PIA1_ADDR + 16'd2, 8'hA5, 1'b0);
        do_wb("pet read col 7", KBD_BASE | 17'd7, 8'h00, 1'b0);
        do_cpu("select col 2", PIA1_ADDR + 16'd4, porta_byte(4'd2, 4'b1111), 1'b1);
        do_cpu("capture col 2", PIA1_ADDR + 16'd6, 8'h5A, 1'b0);
        do_wb("pet read col 2", KBD_BASE | 17'd2, 8'h00, 1'b0);

        // Accesses that must be ignored, column 5 reselected first
        do_cpu("reselect col 5", PIA1_ADDR, porta_byte(4'd5, 4'b0000), 1'b1);
        do_cpu("port A read", PIA1_ADDR, porta_byte(4'd3, 4'b0000), 1'b0);
        do_cpu("CRB read", PIA1_ADDR + 16'd3, 8'h00, 1'b0);
        do_cpu("port B write", PIA1_ADDR + 16'd2, 8'h3C, 1'b1);
        do_cpu("CRA write", PIA1_ADDR + 16'd1, porta_byte(4'd3, 4'b0000), 1'b1);
        do_cpu("outside write", 16'hE820, porta_byte(4'd3, 4'b0000), 1'b1);
        do_cpu("outside read", 16'hE822, 8'h00, 1'b0);
        do_cpu("mirror port B read", PIA1_ADDR + 16'h000A, 8'hC3, 1'b0);
        do_wb("outside window", KBD_BASE + 17'd16, 8'h00, 1'b1);
        do_wb("outside window low", 17'h0E805, 8'h00, 1'b1);
        do_cpu("select col 0", PIA1_ADDR, porta_byte(4'd0, 4'b0000), 1'b1);
        do_cpu("no key col 0", PIA1_ADDR + 16'd2, 8'h81, 1'b0);
        for (i = 10; i < 16; i++) begin
            do_wb("hole read", KBD_BASE | 17'(i), 8'h00, 1'b0);
        end
        do_wb("hole write", KBD_BASE | 17'd12, 8'h00, 1'b1);
        do_cpu("select col 12", PIA1_ADDR, porta_byte(4'd12, 4'b0000), 1'b1);
        do_cpu("hole port B read", PIA1_ADDR + 16'd2, 8'h00, 1'b0);

        // Random mix against the model
        for (i = 0; i < RAND_OPS; i++) begin
            rng  = xorshift32(rng);
            kind = int'(rng % 32'd3);
            if (kind == 0) begin
                col = 4'(rng[15:8] % 8'd10);
                dat = (rng[26:24] == 3'd0) ? 8'hFF : rng[23:16];   // Some columns released
                do_wb("random usb write", KBD_BASE | 17'(col), dat, 1'b1);
            end else if (kind == 1) begin
                col = 4'(rng[15:8] % 8'd12);                       // Holes now and then
                do_cpu("random select", PIA1_ADDR | {12'h000, rng[19:18], 2'b00},
                       porta_byte(col, rng[23:20]), 1'b1);
            end else begin
                do_cpu("random port B read", PIA1_ADDR | {12'h000, rng[19:18], 2'b10},
                       rng[31:24], 1'b0);
            end
        end
        for (i = 0; i < `KBD_COL_COUNT; i++) begin
            do_wb("final pet read", KBD_BASE | 17'(i), 8'h00, 1'b0);
        end

        $display({"Checks done, wishbone errors %0d, override errors %0d, ",
                  "bus timing errors %0d, other errors %0d"},
                 wb_errors, cpu_errors, timing_errors, other_errors);
        if ((wb_errors + cpu_errors + timing_errors + other_errors) == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tb/kbd_subsys_sva.sv
// Keyboard peripheral assertions
// Wishbone acknowledge timing and the CPU override enable
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module kbd_subsys_sva (
    input logic                  wb_clock_i,
    input logic                  rst_i,
    input pet_kbd_pkg::wb_req_t  wb_req_i,
    input pet_kbd_pkg::wb_rsp_t  wb_rsp_o,
    input pet_kbd_pkg::cpu_bus_t cpu_bus_i,
    input logic                  cpu_be_i,
    input logic                  cpu_data_oe_o
);
    localparam logic [`WB_ADDR_WIDTH-1:0]  KBD_ADDR  = `KBD_WB_BASE;
    localparam logic [`CPU_ADDR_WIDTH-1:0] PIA1_ADDR = `PIA1_BASE;

    logic wb_take;
    logic portb_rd_be;

    // Keyboard window taken from the raw WB address
    assign wb_take     = wb_req_i.cyc && wb_req_i.stb
                         && (wb_req_i.adr[`WB_ADDR_WIDTH-1:`KBD_COL_WIDTH]
                             == KBD_ADDR[`WB_ADDR_WIDTH-1:`KBD_COL_WIDTH]);

    // 16 byte PIA1 window, RS1:RS0 on A1:A0
    assign portb_rd_be = cpu_be_i && !cpu_bus_i.we
                         && (cpu_bus_i.addr[`CPU_ADDR_WIDTH-1:4]
                             == PIA1_ADDR[`CPU_ADDR_WIDTH-1:4])
                         && (pet_kbd_pkg::pia_rs_e'(cpu_bus_i.addr[1:0]) == pet_kbd_pkg::PORTB);

    // Exactly one clock from request to acknowledge
    ack_after_req: assert property (@(posedge wb_clock_i) disable iff (rst_i)
        wb_take |=> wb_rsp_o.ack)
        else $error("Acknowledge missing one clock after a selected request");

    ack_only_after_req: assert property (@(posedge wb_clock_i) disable iff (rst_i)
        !wb_take |=> !wb_rsp_o.ack)
        else $error("Acknowledge without a selected request");

    // Override only follows a port B read inside bus enable
    oe_rise_on_portb: assert property (@(posedge wb_clock_i) disable iff (rst_i)
        $rose(cpu_data_oe_o) |-> $past(portb_rd_be))
        else $error("Override enable rose without a PIA1 port B read");

    ack_low_in_reset: assert property (@(posedge wb_clock_i)
        rst_i |=> !wb_rsp_o.ack)
        else $error("Acknowledge high during reset");

endmodule

bind keyboard kbd_subsys_sva u_sva (
    .wb_clock_i    (wb_clock_i),
    .rst_i         (rst_i),
    .wb_req_i      (wb_req_i),
    .wb_rsp_o      (wb_rsp_o),
    .cpu_bus_i     (cpu_bus_i),
    .cpu_be_i      (cpu_be_i),
    .cpu_data_oe_o (cpu_data_oe_o)
);

//--- hdl/kbd_subsys.sv
// PET keyboard subsystem top level
// Ties CPU bus timing, address decoding and the keyboard peripheral together
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module kbd_subsys (
    input  logic                   wb_clock_i,
    input  logic                   rst_i,
    input  pet_kbd_pkg::wb_req_t   wb_req_i,        // From the MCU bridge
    input  pet_kbd_pkg::cpu_bus_t  cpu_bus_i,       // Monitored 6502 bus
    output pet_kbd_pkg::wb_rsp_t   wb_rsp_o,
    output logic [`DATA_WIDTH-1:0] cpu_data_o,
    output logic                   cpu_data_oe_o,
    output logic                   cpu_be_o,        // Tells the CPU model when to drive
    output logic                   cpu_data_strobe_o
);
    logic                 pia1_cs;
    pet_kbd_pkg::pia_rs_e pia1_rs;
    logic                 kbd_sel;

    // Phase only needed by the CPU model through hierarchy
    cpu_bus_timing u_timing (
        .wb_clock_i        (wb_clock_i),
        .rst_i             (rst_i),
        .cpu_be_o          (cpu_be_o),
        .cpu_data_strobe_o (cpu_data_strobe_o),
        .cpu_phase_o       ()
    );

    io_decode u_decode (
        .cpu_bus_i (cpu_bus_i),
        .wb_req_i  (wb_req_i),
        .pia1_cs_o (pia1_cs),
        .pia1_rs_o (pia1_rs),
        .kbd_sel_o (kbd_sel)
    );

    keyboard u_kbd (
        .wb_clock_i        (wb_clock_i),
        .rst_i             (rst_i),
        .wb_req_i          (wb_req_i),
        .wb_sel_i          (kbd_sel),
        .wb_rsp_o          (wb_rsp_o),
        .cpu_bus_i         (cpu_bus_i),
        .cpu_be_i          (cpu_be_o),
        .cpu_data_strobe_i (cpu_data_strobe_o),
        .pia1_cs_i         (pia1_cs),
        .pia1_rs_i         (pia1_rs),
        .cpu_data_o        (cpu_data_o),
        .cpu_data_oe_o     (cpu_data_oe_o)
    );

endmodule

//--- hdl/keyboard.sv
// USB keyboard matrix peripheral on Wishbone
// Caches the PIA1 column, captures PET rows and overrides port B reads when a key is down
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module keyboard (
    input  logic                  wb_clock_i,
    input  logic                  rst_i,

    // Wishbone B4 pipelined, single cycle, no stall
    input  pet_kbd_pkg::wb_req_t  wb_req_i,
    input  logic                  wb_sel_i,         // From io_decode
    output pet_kbd_pkg::wb_rsp_t  wb_rsp_o,

    // 6502 bus monitor
    input  pet_kbd_pkg::cpu_bus_t cpu_bus_i,
    input  logic                  cpu_be_i,
    input  logic                  cpu_data_strobe_i,
    input  logic                  pia1_cs_i,
    input  pet_kbd_pkg::pia_rs_e  pia1_rs_i,
    output logic [`DATA_WIDTH-1:0] cpu_data_o,      // Override data for port B reads
    output logic                  cpu_data_oe_o     // High while intercepting
);
    // Row bits are active low, all ones means no key down
    logic [`KBD_COL_COUNT-1:0][`KBD_ROW_COUNT-1:0] usb_kbd;   // Written by the MCU
    logic [`KBD_COL_COUNT-1:0][`KBD_ROW_COUNT-1:0] pet_kbd;   // Captured from the real PIA

    logic [`KBD_COL_WIDTH-1:0] wb_col;
    logic                      wb_col_ok;
    logic                      wb_take;

    logic [`KBD_COL_WIDTH-1:0] selected_col;                  // Column driven on PIA1 PA3:PA0
    logic                      selected_col_ok;
    logic [`KBD_ROW_COUNT-1:0] selected_row;                  // USB rows of that column

    pet_kbd_pkg::pia1_porta_u  porta_wr;

    logic cpu_porta_wr;
    logic cpu_portb_rd;
    logic cpu_portb_rd_be;

    // Low WB address bits pick the column, 10..15 are holes
    assign wb_col    = wb_req_i.adr[`KBD_COL_WIDTH-1:0];
    assign wb_col_ok = (wb_col < `KBD_COL_COUNT);
    assign wb_take   = wb_sel_i && wb_req_i.cyc && wb_req_i.stb;

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            wb_rsp_o.ack <= 1'b0;
            usb_kbd      <= '1;                               // No USB keys down
        end else begin
            wb_rsp_o.ack <= wb_take;                          // Always one clock later
            if (wb_take && wb_req_i.we && wb_col_ok) begin
                usb_kbd[wb_col] <= wb_req_i.dat;
            end
        end
    end

    // Read data is the PET column before this access
    always_ff @(posedge wb_clock_i) begin
        if (wb_take) begin
            wb_rsp_o.dat <= wb_col_ok ? pet_kbd[wb_col] : '1;
        end
    end

    // CPU side strobes, valid once per CPU cycle in phase 15
    assign porta_wr        = cpu_bus_i.data;                  // Decode the byte as PIA1 port A
    assign cpu_porta_wr    = pia1_cs_i && cpu_data_strobe_i && cpu_bus_i.we
                             && (pia1_rs_i == pet_kbd_pkg::PORTA);
    assign cpu_portb_rd    = pia1_cs_i && cpu_data_strobe_i && !cpu_bus_i.we
                             && (pia1_rs_i == pet_kbd_pkg::PORTB);
    assign selected_col_ok = (selected_col < `KBD_COL_COUNT);

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            selected_col <= '0;
            pet_kbd      <= '1;
        end else begin
            if (cpu_porta_wr) begin
                selected_col <= porta_wr.f.key_col;           // Other PA bits are inputs
            end
            if (cpu_portb_rd && selected_col_ok) begin
                pet_kbd[selected_col] <= cpu_bus_i.data;      // Rows from the real PIA
            end
        end
    end

    // USB rows for the cached column, refreshed every clock
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            selected_row <= '1;
        end else begin
            selected_row <= selected_col_ok ? usb_kbd[selected_col] : '1;
        end
    end

    // Port B read in progress anywhere in the bus enable window
    assign cpu_portb_rd_be = cpu_be_i && !cpu_bus_i.we && pia1_cs_i
                             && (pia1_rs_i == pet_kbd_pkg::PORTB);

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            cpu_data_oe_o <= 1'b0;
        end else begin
            cpu_data_oe_o <= cpu_portb_rd_be && (selected_row != '1);  // Only when a key is down
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (cpu_portb_rd_be) begin
            cpu_data_o <= selected_row;
        end
    end

endmodule

//--- hdl/io_decode.sv
// Address decoder for the CPU and Wishbone sides
// PIA1 chip and register select from the 6502 bus, keyboard select from WB
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module io_decode (
    input  pet_kbd_pkg::cpu_bus_t cpu_bus_i,
    input  pet_kbd_pkg::wb_req_t  wb_req_i,
    output logic                  pia1_cs_o,    // CPU address in the PIA1 window
    output pet_kbd_pkg::pia_rs_e  pia1_rs_o,    // Register within PIA1
    output logic                  kbd_sel_o     // WB address in the keyboard window
);
    // PIA1 window is 16 bytes, the 4 registers repeat in it
    localparam int PIA1_WIN_BITS = 4;
    localparam logic [`CPU_ADDR_WIDTH-1:0] PIA1_ADDR = `PIA1_BASE;

    // Keyboard window is one entry per possible column index
    localparam int KBD_WIN_BITS = `KBD_COL_WIDTH;
    localparam logic [`WB_ADDR_WIDTH-1:0] KBD_ADDR = `KBD_WB_BASE;

    logic [`CPU_ADDR_WIDTH-PIA1_WIN_BITS-1:0] cpu_page;
    logic [`WB_ADDR_WIDTH-KBD_WIN_BITS-1:0]   wb_page;

    // Upper address bits only, low bits are don't care inside a window
    assign cpu_page = cpu_bus_i.addr[`CPU_ADDR_WIDTH-1:PIA1_WIN_BITS];
    assign wb_page  = wb_req_i.adr[`WB_ADDR_WIDTH-1:KBD_WIN_BITS];

    // CPU side
    always_comb begin
        pia1_cs_o = (cpu_page == PIA1_ADDR[`CPU_ADDR_WIDTH-1:PIA1_WIN_BITS]);

        // RS1:RS0 are wired to A1:A0 as on the PET
        pia1_rs_o = pet_kbd_pkg::pia_rs_e'(cpu_bus_i.addr[1:0]);
    end

    // Wishbone side
    always_comb begin
        kbd_sel_o = (wb_page == KBD_ADDR[`WB_ADDR_WIDTH-1:KBD_WIN_BITS]);
    end

endmodule

//--- hdl/cpu_bus_timing.sv
// CPU bus phase generator
// Splits the WB clock into 16 clock CPU cycles with bus enable and data strobe
`timescale 1ns/10ps
`include "pet_kbd_params.svh"

module cpu_bus_timing (
    input  logic                                  wb_clock_i,
    input  logic                                  rst_i,
    output logic                                  cpu_be_o,          // CPU owns the bus
    output logic                                  cpu_data_strobe_o, // Data valid, end of cycle
    output logic [$clog2(`CPU_CYCLE_CLOCKS)-1:0]  cpu_phase_o
);
    localparam int PHASE_WIDTH = $clog2(`CPU_CYCLE_CLOCKS);

    // Phase where bus enable rises and phase holding the strobe
    localparam logic [PHASE_WIDTH-1:0] PHASE_BE   = PHASE_WIDTH'(`CPU_BE_START);
    localparam logic [PHASE_WIDTH-1:0] PHASE_LAST = PHASE_WIDTH'(`CPU_CYCLE_CLOCKS - 1);

    logic [PHASE_WIDTH-1:0] phase_q;
    logic [PHASE_WIDTH-1:0] phase_next;

    // Wrap at the end of the CPU cycle
    always_comb begin
        if (phase_q == PHASE_LAST) begin
            phase_next = '0;
        end else begin
            phase_next = phase_q + 1'b1;
        end
    end

    // Outputs registered from the next phase so they line up with phase_q
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            phase_q           <= '0;                 // Start of a CPU cycle
            cpu_be_o          <= 1'b0;
            cpu_data_strobe_o <= 1'b0;
        end else begin
            phase_q           <= phase_next;
            cpu_be_o          <= (phase_next >= PHASE_BE);   // Phases 8..15
            cpu_data_strobe_o <= (phase_next == PHASE_LAST); // One clock in phase 15
        end
    end

    // Phase index for the CPU side model
    assign cpu_phase_o = phase_q;

endmodule

//--- hdl/pet_kbd_pkg.sv
// PET keyboard subsystem types
// Bus bundles, PIA1 port A view and PIA register select
`include "pet_kbd_params.svh"

package pet_kbd_pkg;

    // Wishbone B4 request from the MCU bridge
    typedef struct packed {
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [`DATA_WIDTH-1:0]    dat;     // Write data
        logic                      we;
        logic                      cyc;
        logic                      stb;
    } wb_req_t;

    // Wishbone response, never stalls
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] dat;        // Read data
        logic                   ack;
    } wb_rsp_t;

    // 6502 bus as seen by the monitor
    typedef struct packed {
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;   // Data on the bus, either direction
        logic                       we;
    } cpu_bus_t;

    // 6520 PIA register select, RS1:RS0
    typedef enum logic [1:0] {
        PORTA = 2'd0,
        CRA   = 2'd1,
        PORTB = 2'd2,
        CRB   = 2'd3
    } pia_rs_e;

    // PIA1 port A, raw byte or PET signal fields
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;
        struct packed {
            logic                      diag;        // PA7 diagnostic sense
            logic                      eoi;         // PA6 IEEE-488 EOI in
            logic [1:0]                cass_sense;  // PA5:PA4 cassette switches
            logic [`KBD_COL_WIDTH-1:0] key_col;     // PA3:PA0 keyboard column
        } f;
    } pia1_porta_u;

endpackage

//--- hdl/pet_kbd_params.svh
// PET keyboard subsystem parameters
// Bus widths, matrix geometry, address windows and CPU bus timing
`ifndef PET_KBD_PARAMS_SVH
`define PET_KBD_PARAMS_SVH

// Bus widths
`define DATA_WIDTH       8
`define WB_ADDR_WIDTH    17
`define CPU_ADDR_WIDTH   16

// Keyboard matrix, 10 columns of 8 rows
`define KBD_COL_COUNT    10
`define KBD_ROW_COUNT    8
`define KBD_COL_WIDTH    4                // Also the size of the WB window in address bits

// Address windows
`define KBD_WB_BASE      17'h1E800        // 16 word WB window, low bits pick the column
`define PIA1_BASE        16'hE810         // PIA1 decodes E810..E81F

// CPU bus timing in WB clocks
// The CPU owns the bus in the second half of every cycle
`define CPU_CYCLE_CLOCKS 16
`define CPU_BE_START     8

`endif
